//--- rtl/core_ctrl_pkg.sv
`default_nettype none

package core_ctrl_pkg;

    // datapath
    localparam int XLEN = 32;                        // data and address width

    // divider
    localparam int DIV_CYCLES = XLEN;                // one quotient bit per cycle
    localparam int DIV_CNT_W  = $clog2(DIV_CYCLES + 1);

    // AXI4-Lite response codes
    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    // memory-stage control states
    typedef enum logic [1:0] {
        ST_IDLE     = 2'd0,                          // ready for a new instruction
        ST_RD_WAIT  = 2'd1,                          // read address taken, awaiting data
        ST_DIV_WAIT = 2'd2                           // divider running
    } ctrl_state_e;

    // operation offered at the memory stage
    typedef enum logic [1:0] {
        OP_NONE  = 2'd0,
        OP_LOAD  = 2'd1,
        OP_STORE = 2'd2,
        OP_DIV   = 2'd3
    } mem_op_e;

endpackage

`default_nettype wire

//--- rtl/stall_fsm.sv
`default_nettype none

module stall_fsm import core_ctrl_pkg::*; (
    input  logic clk,
    input  logic rst_n,

    // pipeline side
    input  logic mem_en_i,
    input  logic mem_we_i,
    input  logic div_start_i,
    input  logic reg_we_i,
    input  logic csr_we_i,
    input  logic iram_busy_i,
    input  logic trap_in_i,
    input  logic halt_req_i,
    input  logic trap_jump_i,
    input  logic mret_i,

    // status from bus port and divider
    input  logic wr_done_i,
    input  logic ar_done_i,
    input  logic rd_ok_i,
    input  logic rd_err_i,
    input  logic div_done_i,

    // requests to bus port and divider
    output logic wr_req_o,
    output logic rd_req_o,
    output logic rd_wait_o,
    output logic div_go_o,
    output logic div_kill_o,

    // pipeline outputs
    output logic retire_o,
    output logic load_err_o,
    output logic reg_we_o,
    output logic csr_we_o,
    output logic iram_rd_o,
    output logic trap_stat_o
);

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    mem_op_e     op;
    logic        abort;
    logic        run_q;                              // high once out of reset
    logic        idle_go;                            // idle and free to start work
    logic        retire_raw;

    assign abort   = trap_in_i | halt_req_i;
    assign idle_go = (state_q == ST_IDLE) & run_q & ~abort;

    // division wins over store, store over load
    always_comb begin
        if (div_start_i) begin
            op = OP_DIV;
        end else if (mem_en_i && mem_we_i) begin
            op = OP_STORE;
        end else if (mem_en_i) begin
            op = OP_LOAD;
        end else begin
            op = OP_NONE;
        end
    end

    // store held back while iram is busy so it never writes twice
    assign wr_req_o   = idle_go & (op == OP_STORE) & ~iram_busy_i;
    assign rd_req_o   = idle_go & (op == OP_LOAD);
    assign div_go_o   = idle_go & (op == OP_DIV);
    assign rd_wait_o  = (state_q == ST_RD_WAIT);
    assign div_kill_o = abort;                       // harmless when divider is idle

    always_comb begin
        state_d    = state_q;
        retire_raw = 1'b0;
        load_err_o = 1'b0;
        case (state_q)
            ST_IDLE: begin
                if (div_go_o) begin
                    state_d = ST_DIV_WAIT;
                end else if (ar_done_i) begin
                    state_d = ST_RD_WAIT;
                end
                if (idle_go && !iram_busy_i) begin
                    retire_raw = (op == OP_NONE) | ((op == OP_STORE) & wr_done_i);
                end
            end
            ST_RD_WAIT: begin
                if (abort || rd_ok_i || rd_err_i) begin
                    state_d = ST_IDLE;
                end
                retire_raw = rd_ok_i & ~abort;
                load_err_o = rd_err_i & ~abort;      // one cycle, state leaves next edge
            end
            ST_DIV_WAIT: begin
                if (abort || div_done_i) begin
                    state_d = ST_IDLE;
                end
                retire_raw = div_done_i & ~abort;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    assign retire_o = retire_raw & run_q;

    // load errors never retire, so reg_we_o stays low for them too
    assign reg_we_o  = reg_we_i & retire_o;
    assign csr_we_o  = csr_we_i & retire_o;
    assign iram_rd_o = retire_o | trap_jump_i;       // fetch on retire or trap entry

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
            run_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            run_q   <= 1'b1;
        end
    end

    // trap status, set by trap entry and cleared by a retiring mret
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            trap_stat_o <= 1'b0;
        end else if (!trap_stat_o) begin
            if (trap_jump_i) begin
                trap_stat_o <= 1'b1;
            end
        end else if (mret_i && retire_o) begin
            trap_stat_o <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- rtl/iter_divider.sv
`default_nettype none

module iter_divider import core_ctrl_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,

    input  logic            go_i,                    // load operands, start
    input  logic            kill_i,                  // drop the division in flight
    input  logic [XLEN-1:0] dividend_i,
    input  logic [XLEN-1:0] divisor_i,

    output logic            done_o,                  // one-cycle pulse, results valid
    output logic [XLEN-1:0] quot_o,
    output logic [XLEN-1:0] rem_o
);

    logic [DIV_CNT_W-1:0] cnt_q;                     // iterations left
    logic                 done_q;
    logic [XLEN-1:0]      quot_q;                    // dividend shifts out, quotient in
    logic [XLEN-1:0]      rem_q;
    logic [XLEN-1:0]      dsor_q;
    logic [XLEN:0]        rem_shift;
    logic [XLEN:0]        rem_sub;
    logic                 q_bit;
    logic                 busy;

    assign busy = (cnt_q != '0);

    // one restoring step: shift in next dividend bit, try the subtract
    always_comb begin
        rem_shift = {rem_q, quot_q[XLEN-1]};
        rem_sub   = rem_shift - {1'b0, dsor_q};
        q_bit     = ~rem_sub[XLEN];                  // no borrow means it fits
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q  <= '0;
            done_q <= 1'b0;
        end else if (kill_i) begin
            cnt_q  <= '0;
            done_q <= 1'b0;
        end else if (go_i) begin
            cnt_q  <= DIV_CNT_W'(DIV_CYCLES);
            done_q <= 1'b0;
        end else begin
            if (busy) begin
                cnt_q <= cnt_q - 1'b1;
            end
            done_q <= (cnt_q == DIV_CNT_W'(1));      // last step lands this edge
        end
    end

    // a zero divisor always subtracts nothing, so the quotient fills with
    // ones and the dividend ends up in the remainder, as RISC-V requires
    always_ff @(posedge clk) begin
        if (go_i) begin
            quot_q <= dividend_i;
            rem_q  <= '0;
            dsor_q <= divisor_i;
        end else if (busy) begin
            quot_q <= {quot_q[XLEN-2:0], q_bit};
            rem_q  <= q_bit ? rem_sub[XLEN-1:0] : rem_shift[XLEN-1:0];
        end
    end

    assign done_o = done_q;
    assign quot_o = quot_q;                          // held until next go
    assign rem_o  = rem_q;

endmodule

`default_nettype wire

//--- rtl/axil_mem_port.sv
`default_nettype none

module axil_mem_port import core_ctrl_pkg::*; (
    // requests from the control FSM
    input  logic            wr_req_i,
    input  logic            rd_req_i,
    input  logic            rd_wait_i,
    input  logic [XLEN-1:0] addr_i,
    input  logic [XLEN-1:0] wdata_i,
    input  logic [3:0]      wstrb_i,

    // status back to the control FSM
    output logic            wr_done_o,
    output logic            ar_done_o,
    output logic            rd_ok_o,
    output logic            rd_err_o,
    output logic [XLEN-1:0] rdata_o,

    // AW channel
    output logic [XLEN-1:0] m_awaddr_o,
    output logic            m_awvalid_o,
    input  logic            m_awready_i,
    // W channel
    output logic [XLEN-1:0] m_wdata_o,
    output logic [3:0]      m_wstrb_o,
    output logic            m_wvalid_o,
    input  logic            m_wready_i,
    // B channel
    input  logic            m_bvalid_i,              // responses accepted and dropped
    input  logic [1:0]      m_bresp_i,
    output logic            m_bready_o,
    // AR channel
    output logic [XLEN-1:0] m_araddr_o,
    output logic            m_arvalid_o,
    input  logic            m_arready_i,
    // R channel
    input  logic [XLEN-1:0] m_rdata_i,
    input  logic [1:0]      m_rresp_i,
    input  logic            m_rvalid_i,
    output logic            m_rready_o
);

    logic [XLEN-1:0] word_addr;
    logic            r_beat;

    assign word_addr = {addr_i[XLEN-1:2], 2'b00};    // strobes pick the bytes

    // write address and data go out together
    assign m_awaddr_o  = word_addr;
    assign m_awvalid_o = wr_req_i;
    assign m_wdata_o   = wdata_i;
    assign m_wstrb_o   = wstrb_i;
    assign m_wvalid_o  = wr_req_i;
    assign m_bready_o  = 1'b1;

    assign m_araddr_o  = word_addr;
    assign m_arvalid_o = rd_req_i;
    assign m_rready_o  = 1'b1;

    // slave takes AW and W in the same cycle
    assign wr_done_o = wr_req_i & m_awready_i & m_wready_i;
    assign ar_done_o = rd_req_i & m_arready_i;

    assign r_beat   = rd_wait_i & m_rvalid_i;
    assign rd_ok_o  = r_beat & (m_rresp_i == AXI_RESP_OKAY);
    assign rd_err_o = r_beat & (m_rresp_i != AXI_RESP_OKAY);
    assign rdata_o  = rd_wait_i ? m_rdata_i : '0;

endmodule

`default_nettype wire

//--- rtl/core_ctrl_top.sv
`default_nettype none

module core_ctrl_top import core_ctrl_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,

    // memory stage
    input  logic            mem_en_i,
    input  logic            mem_we_i,
    input  logic [XLEN-1:0] mem_addr_i,
    input  logic [XLEN-1:0] mem_wdata_i,
    input  logic [3:0]      mem_wstrb_i,
    input  logic            div_start_i,
    input  logic [XLEN-1:0] dividend_i,
    input  logic [XLEN-1:0] divisor_i,
    input  logic            reg_we_i,
    input  logic            csr_we_i,

    // stall and trap sources
    input  logic            iram_busy_i,
    input  logic            trap_in_i,
    input  logic            halt_req_i,
    input  logic            trap_jump_i,
    input  logic            mret_i,

    // pipeline results
    output logic            retire_o,                // write-back valid
    output logic [XLEN-1:0] mem_rdata_o,
    output logic [XLEN-1:0] div_quot_o,
    output logic [XLEN-1:0] div_rem_o,
    output logic            load_err_o,
    output logic            reg_we_o,
    output logic            csr_we_o,
    output logic            iram_rd_o,
    output logic            trap_stat_o,

    // AXI4-Lite master
    output logic [XLEN-1:0] m_awaddr_o,
    output logic            m_awvalid_o,
    input  logic            m_awready_i,
    output logic [XLEN-1:0] m_wdata_o,
    output logic [3:0]      m_wstrb_o,
    output logic            m_wvalid_o,
    input  logic            m_wready_i,
    input  logic            m_bvalid_i,
    input  logic [1:0]      m_bresp_i,
    output logic            m_bready_o,
    output logic [XLEN-1:0] m_araddr_o,
    output logic            m_arvalid_o,
    input  logic            m_arready_i,
    input  logic [XLEN-1:0] m_rdata_i,
    input  logic [1:0]      m_rresp_i,
    input  logic            m_rvalid_i,
    output logic            m_rready_o
);

    logic wr_req;
    logic rd_req;
    logic rd_wait;
    logic wr_done;
    logic ar_done;
    logic rd_ok;
    logic rd_err;
    logic div_go;
    logic div_kill;
    logic div_done;

    stall_fsm u_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_en_i     (mem_en_i),
        .mem_we_i     (mem_we_i),
        .div_start_i  (div_start_i),
        .reg_we_i     (reg_we_i),
        .csr_we_i     (csr_we_i),
        .iram_busy_i  (iram_busy_i),
        .trap_in_i    (trap_in_i),
        .halt_req_i   (halt_req_i),
        .trap_jump_i  (trap_jump_i),
        .mret_i       (mret_i),
        .wr_done_i    (wr_done),
        .ar_done_i    (ar_done),
        .rd_ok_i      (rd_ok),
        .rd_err_i     (rd_err),
        .div_done_i   (div_done),
        .wr_req_o     (wr_req),
        .rd_req_o     (rd_req),
        .rd_wait_o    (rd_wait),
        .div_go_o     (div_go),
        .div_kill_o   (div_kill),
        .retire_o     (retire_o),
        .load_err_o   (load_err_o),
        .reg_we_o     (reg_we_o),
        .csr_we_o     (csr_we_o),
        .iram_rd_o    (iram_rd_o),
        .trap_stat_o  (trap_stat_o)
    );

    iter_divider u_div (
        .clk          (clk),
        .rst_n        (rst_n),
        .go_i         (div_go),
        .kill_i       (div_kill),
        .dividend_i   (dividend_i),
        .divisor_i    (divisor_i),
        .done_o       (div_done),
        .quot_o       (div_quot_o),
        .rem_o        (div_rem_o)
    );

    axil_mem_port u_bus (
        .wr_req_i     (wr_req),
        .rd_req_i     (rd_req),
        .rd_wait_i    (rd_wait),
        .addr_i       (mem_addr_i),
        .wdata_i      (mem_wdata_i),
        .wstrb_i      (mem_wstrb_i),
        .wr_done_o    (wr_done),
        .ar_done_o    (ar_done),
        .rd_ok_o      (rd_ok),
        .rd_err_o     (rd_err),
        .rdata_o      (mem_rdata_o),
        .m_awaddr_o   (m_awaddr_o),
        .m_awvalid_o  (m_awvalid_o),
        .m_awready_i  (m_awready_i),
        .m_wdata_o    (m_wdata_o),
        .m_wstrb_o    (m_wstrb_o),
        .m_wvalid_o   (m_wvalid_o),
        .m_wready_i   (m_wready_i),
        .m_bvalid_i   (m_bvalid_i),
        .m_bresp_i    (m_bresp_i),
        .m_bready_o   (m_bready_o),
        .m_araddr_o   (m_araddr_o),
        .m_arvalid_o  (m_arvalid_o),
        .m_arready_i  (m_arready_i),
        .m_rdata_i    (m_rdata_i),
        .m_rresp_i    (m_rresp_i),
        .m_rvalid_i   (m_rvalid_i),
        .m_rready_o   (m_rready_o)
    );

endmodule

`default_nettype wire

//--- dv/core_ctrl_sva.sv
`default_nettype none

module core_ctrl_sva import core_ctrl_pkg::*; (
    input logic        clk,
    input logic        rst_n,
    input logic        abort_i,
    input logic        wr_req_i,                     // awvalid and wvalid
    input logic        rd_req_i,                     // arvalid
    input logic        div_go_i,
    input logic        ar_done_i,
    input logic        retire_i,
    input logic        load_err_i,
    input logic        div_done_i,
    input ctrl_state_e state_i
);

    timeunit 1ns;
    timeprecision 1ps;

    a_abort_drops_valids: assert property (@(posedge clk) disable iff (!rst_n)
        abort_i |-> !wr_req_i && !rd_req_i && !div_go_i)
        else $error("bus valid or divider start high during an abort");

    a_retire_xor_err: assert property (@(posedge clk) disable iff (!rst_n)
        !(retire_i && load_err_i))
        else $error("retire and load error high in the same cycle");

    // divider wait ends only on done or abort
    a_div_wait_hold: assert property (@(posedge clk) disable iff (!rst_n)
        state_i == ST_DIV_WAIT && !div_done_i && !abort_i |=> state_i == ST_DIV_WAIT)
        else $error("divider wait left without done or abort");

    a_arvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rd_req_i && !ar_done_i |=> rd_req_i || abort_i)
        else $error("arvalid dropped before arready");

endmodule

bind stall_fsm core_ctrl_sva u_sva (
    .clk        (clk),
    .rst_n      (rst_n),
    .abort_i    (abort),
    .wr_req_i   (wr_req_o),
    .rd_req_i   (rd_req_o),
    .div_go_i   (div_go_o),
    .ar_done_i  (ar_done_i),
    .retire_i   (retire_o),
    .load_err_i (load_err_o),
    .div_done_i (div_done_i),
    .state_i    (state_q)
);

`default_nettype wire

//--- dv/core_ctrl_tb.sv
`default_nettype none

module core_ctrl_tb import core_ctrl_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int         N_ENTRIES   = 21;
    localparam int         CYCLE_LIMIT = N_ENTRIES * (DIV_CYCLES + 16);
    localparam logic [1:0] INJ_NONE    = 2'd0;
    localparam logic [1:0] INJ_TRAP    = 2'd1;
    localparam logic [1:0] INJ_HALT    = 2'd2;

    // one memory-stage instruction and what it should produce
    typedef struct packed {
        mem_op_e         kind;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        logic [3:0]      strb;
        logic [XLEN-1:0] dvd;
        logic [XLEN-1:0] dvs;
        logic            reg_we;
        logic            csr_we;
        logic [1:0]      inject;                     // abort once the op is waiting
        logic [2:0]      busy;                       // cycles of iram_busy_i
        logic            trap_jump;
        logic            mret;
        logic            exp_err;
    } entry_t;

    logic clk;
    logic rst_n;
    logic mem_en_i, mem_we_i, div_start_i, reg_we_i, csr_we_i;
    logic iram_busy_i, trap_in_i, halt_req_i, trap_jump_i, mret_i;
    logic [XLEN-1:0] mem_addr_i, mem_wdata_i, dividend_i, divisor_i;
    logic [3:0]      mem_wstrb_i;
    logic retire_o, load_err_o, reg_we_o, csr_we_o, iram_rd_o, trap_stat_o;
    logic [XLEN-1:0] mem_rdata_o, div_quot_o, div_rem_o;
    logic [XLEN-1:0] m_awaddr_o, m_wdata_o, m_araddr_o, m_rdata_i;
    logic [3:0]      m_wstrb_o;
    logic m_awvalid_o, m_awready_i, m_wvalid_o, m_wready_i, m_bvalid_i, m_bready_o;
    logic m_arvalid_o, m_arready_i, m_rvalid_i, m_rready_o;
    logic [1:0]      m_bresp_i, m_rresp_i;

    entry_t          table_q [N_ENTRIES];
    logic [XLEN-1:0] shadow [64];                    // expected memory contents
    logic [XLEN-1:0] slave_mem [64];
    logic [31:0]     rng;
    logic            exp_trap;
    int              cycle_count;

    // slave state, updated on the rising edge
    int              aw_wait, wr_delay, ar_wait, ar_delay, r_wait, r_delay;
    logic            rd_busy, b_pend;
    logic [XLEN-1:0] rd_addr;

    core_ctrl_top u_core_ctrl_top (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [XLEN-1:0] fill_word(input logic [31:0] idx);
        return (idx * 32'h9E37_79B1) ^ 32'hC3A5_0F1E;
    endfunction

    task automatic next_delay(output int d);
        rng = lcg_next(rng);
        d = int'(rng[17:16]);                        // 0 to 3 cycles
    endtask

    task automatic stop_run();
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic fail_now(input string what);
        $display("Error: %s", what);
        stop_run();
    endtask

    task automatic mismatch(input string name, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] exp);
        $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
        stop_run();
    endtask

    task automatic add_entry(input int i, input mem_op_e kind, input logic [31:0] addr,
                             input logic [31:0] wdata, input logic [3:0] strb,
                             input logic [31:0] dvd, input logic [31:0] dvs,
                             input logic rwe, input logic cwe, input logic [1:0] inj,
                             input logic [2:0] busy, input logic tj, input logic mret,
                             input logic err);
        table_q[i] = '{kind, addr, wdata, strb, dvd, dvs, rwe, cwe, inj, busy, tj, mret, err};
    endtask

    task automatic apply_store(input entry_t e);
        for (int b = 0; b < 4; b++) begin
            if (e.strb[b]) begin
                shadow[e.addr[7:2]][8*b +: 8] = e.wdata[8*b +: 8];
            end
        end
    endtask

    task automatic build_table();
        add_entry(0,  OP_STORE, 32'h10,  32'h1122_3344, 4'hF, 0, 0, 0, 0, INJ_NONE, 0, 0, 0, 0);
        add_entry(1,  OP_STORE, 32'h13,  32'hAABB_CCDD, 4'h5, 0, 0, 0, 0, INJ_NONE, 0, 0, 0, 0);
        add_entry(2,  OP_LOAD,  32'h10,  0, 0, 0, 0, 1, 0, INJ_NONE, 0, 0, 0, 0);
        add_entry(3,  OP_STORE, 32'h20,  32'hDEAD_BEEF, 4'h8, 0, 0, 0, 0, INJ_NONE, 3, 0, 0, 0);
        add_entry(4,  OP_LOAD,  32'h22,  0, 0, 0, 0, 1, 0, INJ_NONE, 0, 0, 0, 0);
        add_entry(5,  OP_LOAD,  32'h31,  0, 0, 0, 0, 1, 0, INJ_NONE, 0, 0, 0, 0);
        add_entry(6,  OP_DIV,   0, 0, 0, 32'd100, 32'd7, 1, 0, INJ_NONE, 0, 0, 0, 0);
        add_entry(7,  OP_DIV,   0, 0, 0, 32'h1234_5678, 32'd0, 1, 0, INJ_NONE, 0, 0, 0, 0);
        add_entry(8,  OP_DIV,   0, 0, 0, 32'd3, 32'd10, 1, 0, INJ_NONE, 0, 0, 0, 0);
        add_entry(9,  OP_DIV,   0, 0, 0, 32'hFFFF_FFFF, 32'd1, 0, 1, INJ_NONE, 0, 0, 0, 0);
        add_entry(10, OP_NONE,  0, 0, 0, 0, 0, 1, 1, INJ_NONE, 5, 0, 0, 0);
        add_entry(11, OP_LOAD,  32'h14,  0, 0, 0, 0, 1, 0, INJ_TRAP, 0, 0, 0, 0);
        add_entry(12, OP_DIV,   0, 0, 0, 32'd1000, 32'd3, 1, 0, INJ_HALT, 0, 0, 0, 0);
        add_entry(13, OP_LOAD,  32'h10,  0, 0, 0, 0, 1, 0, INJ_NONE, 0, 0, 0, 0);
        add_entry(14, OP_LOAD,  32'hF04, 0, 0, 0, 0, 1, 0, INJ_NONE, 0, 0, 0, 1);
        add_entry(15, OP_NONE,  0, 0, 0, 0, 0, 0, 0, INJ_NONE, 2, 1, 0, 0);
        add_entry(16, OP_NONE,  0, 0, 0, 0, 0, 1, 0, INJ_NONE, 0, 0, 0, 0);
        add_entry(17, OP_DIV,   0, 0, 0, 32'd77, 32'd5, 1, 0, INJ_NONE, 0, 0, 0, 0);
        add_entry(18, OP_NONE,  0, 0, 0, 0, 0, 0, 1, INJ_NONE, 2, 0, 1, 0);
        add_entry(19, OP_STORE, 32'h14,  32'h0000_A5A5, 4'h3, 0, 0, 0, 0, INJ_NONE, 2, 0, 0, 0);
        add_entry(20, OP_LOAD,  32'h17,  0, 0, 0, 0, 1, 0, INJ_NONE, 0, 0, 0, 0);
    endtask

    // AXI4-Lite slave, handshakes seen on the rising edge
    always @(posedge clk) begin
        b_pend = 1'b0;
        if (m_awvalid_o && m_wvalid_o && m_awready_i && m_wready_i) begin
            for (int b = 0; b < 4; b++) begin
                if (m_wstrb_o[b]) begin
                    slave_mem[m_awaddr_o[7:2]][8*b +: 8] = m_wdata_o[8*b +: 8];
                end
            end
            aw_wait = 0;
            next_delay(wr_delay);
            b_pend = 1'b1;
        end else if (m_awvalid_o) begin
            aw_wait++;
        end
        if (rd_busy && m_rvalid_i) begin
            rd_busy = 1'b0;                          // rready is tied high
        end else if (rd_busy) begin
            r_wait++;
        end
        if (m_arvalid_o && m_arready_i) begin
            rd_busy = 1'b1;
            rd_addr = m_araddr_o;
            r_wait  = 0;
            ar_wait = 0;
            next_delay(r_delay);
            next_delay(ar_delay);
        end else if (m_arvalid_o) begin
            ar_wait++;
        end
    end

    always @(negedge clk) begin
        m_awready_i = (aw_wait >= wr_delay);
        m_wready_i  = (aw_wait >= wr_delay);
        m_bvalid_i  = b_pend;
        m_arready_i = !rd_busy && (ar_wait >= ar_delay);
        m_rvalid_i  = rd_busy && (r_wait >= r_delay);
        m_rdata_i   = m_rvalid_i ? slave_mem[rd_addr[7:2]] : '0;
        m_rresp_i   = (rd_busy && rd_addr[11:8] == 4'hF) ? 2'b10 : AXI_RESP_OKAY;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            fail_now("timeout, the entries did not finish within the cycle limit");
        end
    end

    initial begin
        entry_t          e;
        int              cyc;
        logic            ended;
        logic            in_wait;
        logic [XLEN-1:0] word_a;
        logic [XLEN-1:0] exp_q;
        logic [XLEN-1:0] exp_r;
        clk = 1'b0;
        rst_n = 1'b0;
        {mem_en_i, mem_we_i, div_start_i, reg_we_i, csr_we_i} = '0;
        {iram_busy_i, trap_in_i, halt_req_i, trap_jump_i, mret_i} = '0;
        {mem_addr_i, mem_wdata_i, dividend_i, divisor_i, mem_wstrb_i} = '0;
        {m_awready_i, m_wready_i, m_bvalid_i, m_arready_i, m_rvalid_i} = '0;
        m_bresp_i = AXI_RESP_OKAY;
        m_rresp_i = AXI_RESP_OKAY;
        m_rdata_i = '0;
        rng = 32'd45873;
        {aw_wait, wr_delay, ar_wait, ar_delay, r_wait, r_delay} = '0;
        rd_busy = 1'b0;
        b_pend = 1'b0;
        rd_addr = '0;
        exp_trap = 1'b0;
        cycle_count = 0;
        for (int i = 0; i < 64; i++) begin
            shadow[i]    = fill_word(i * 4);
            slave_mem[i] = fill_word(i * 4);
        end
        build_table();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < N_ENTRIES; i++) begin
            e = table_q[i];
            word_a = e.addr & ~32'h3;                // two low bits cleared
            cyc = 0;
            ended = 1'b0;
            while (!ended) begin
                @(negedge clk);
                in_wait     = (u_core_ctrl_top.u_fsm.state_q != ST_IDLE);
                mem_en_i    = (e.kind == OP_LOAD) || (e.kind == OP_STORE);
                mem_we_i    = (e.kind == OP_STORE);
                div_start_i = (e.kind == OP_DIV);
                mem_addr_i  = e.addr;
                mem_wdata_i = e.wdata;
                mem_wstrb_i = e.strb;
                dividend_i  = e.dvd;
                divisor_i   = e.dvs;
                reg_we_i    = e.reg_we;
                csr_we_i    = e.csr_we;
                trap_jump_i = e.trap_jump;
                mret_i      = e.mret;
                iram_busy_i = (cyc < int'(e.busy));
                trap_in_i   = (e.inject == INJ_TRAP) && in_wait;
                halt_req_i  = (e.inject == INJ_HALT) && in_wait;
                #5;                                  // outputs settled, edge still ahead
                assert (trap_stat_o == exp_trap)
                    else mismatch("trap_stat_o", 32'(trap_stat_o), 32'(exp_trap));
                assert (m_bready_o) else mismatch("m_bready_o", 32'(m_bready_o), 32'd1);
                assert (m_rready_o) else mismatch("m_rready_o", 32'(m_rready_o), 32'd1);
                assert (!(retire_o && iram_busy_i))
                    else fail_now("retire_o went high while iram_busy_i was held");
                if (m_awvalid_o) begin
                    assert (m_wvalid_o) else mismatch("m_wvalid_o", 32'(m_wvalid_o), 32'd1);
                    assert (m_awaddr_o == word_a)
                        else mismatch("m_awaddr_o", m_awaddr_o, word_a);
                    assert (m_wdata_o == e.wdata)
                        else mismatch("m_wdata_o", m_wdata_o, e.wdata);
                    assert (m_wstrb_o == e.strb)
                        else mismatch("m_wstrb_o", 32'(m_wstrb_o), 32'(e.strb));
                end
                if (m_arvalid_o) begin
                    assert (m_araddr_o == word_a)
                        else mismatch("m_araddr_o", m_araddr_o, word_a);
                end
                if (trap_in_i || halt_req_i) begin
                    assert (!retire_o) else fail_now("an aborted entry retired");
                    assert (!load_err_o) else fail_now("load error reported during abort");
                    ended = 1'b1;
                end else if (load_err_o) begin
                    assert (e.exp_err) else fail_now("load error on a good address");
                    assert (!reg_we_o) else mismatch("reg_we_o", 32'(reg_we_o), 32'd0);
                    ended = 1'b1;
                end else if (retire_o) begin
                    assert (!e.exp_err) else fail_now("load from the error range retired");
                    assert (reg_we_o == e.reg_we)
                        else mismatch("reg_we_o", 32'(reg_we_o), 32'(e.reg_we));
                    assert (csr_we_o == e.csr_we)
                        else mismatch("csr_we_o", 32'(csr_we_o), 32'(e.csr_we));
                    assert (iram_rd_o) else mismatch("iram_rd_o", 32'(iram_rd_o), 32'd1);
                    if (e.kind == OP_LOAD) begin
                        assert (mem_rdata_o == shadow[e.addr[7:2]])
                            else mismatch("mem_rdata_o", mem_rdata_o, shadow[e.addr[7:2]]);
                    end else if (e.kind == OP_STORE) begin
                        apply_store(e);
                    end else if (e.kind == OP_DIV) begin
                        // RISC-V: x / 0 gives all ones, remainder x
                        exp_q = (e.dvs == '0) ? '1 : e.dvd / e.dvs;
                        exp_r = (e.dvs == '0) ? e.dvd : e.dvd % e.dvs;
                        assert (div_quot_o == exp_q) else mismatch("div_quot_o", div_quot_o, exp_q);
                        assert (div_rem_o == exp_r) else mismatch("div_rem_o", div_rem_o, exp_r);
                    end
                    if (e.mret) begin
                        exp_trap = 1'b0;
                    end
                    ended = 1'b1;
                end else begin
                    assert (!reg_we_o) else mismatch("reg_we_o", 32'(reg_we_o), 32'd0);
                    assert (!csr_we_o) else mismatch("csr_we_o", 32'(csr_we_o), 32'd0);
                    assert (iram_rd_o == e.trap_jump)
                        else mismatch("iram_rd_o", 32'(iram_rd_o), 32'(e.trap_jump));
                end
                if (e.trap_jump) begin
                    exp_trap = 1'b1;                 // status follows on the next edge
                end
                cyc++;
            end
        end
        @(negedge clk);
        #5;
        assert (trap_stat_o == exp_trap)
            else mismatch("trap_stat_o", 32'(trap_stat_o), 32'(exp_trap));
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
rtl/core_ctrl_pkg.sv
rtl/stall_fsm.sv
rtl/iter_divider.sv
rtl/axil_mem_port.sv
rtl/core_ctrl_top.sv
dv/core_ctrl_sva.sv
dv/core_ctrl_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= core_ctrl_tb
FLIST     ?= flist.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN = $(BUILD)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FLIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "ALL CHECKS PASSED" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
